// File: design/sam_pkg.sv
/*
 * SAM ASIC glue package
 * Port addresses, decoded port and MIDI state enums, timer and audio constants
 */

package sam_pkg;

	// ========================================
	// I/O port addresses (low address byte)
	// ========================================
	localparam logic [7:0] ADDR_EXT_C = 8'd128;
	localparam logic [7:0] ADDR_EXT_D = 8'd129;
	localparam logic [7:0] ADDR_LPTD  = 8'd232;
	localparam logic [7:0] ADDR_LPTS  = 8'd233;
	localparam logic [7:0] ADDR_STAT  = 8'd249;
	localparam logic [7:0] ADDR_LMPR  = 8'd250;
	localparam logic [7:0] ADDR_HMPR  = 8'd251;
	localparam logic [7:0] ADDR_MIDI  = 8'd253;
	localparam logic [7:0] ADDR_BRDR  = 8'd254;

	// Decoded port, one value per register block
	typedef enum logic [3:0] {
		PORT_NONE,
		PORT_EXT_C,
		PORT_EXT_D,
		PORT_LPTD,
		PORT_LPTS,
		PORT_STAT,
		PORT_LMPR,
		PORT_HMPR,
		PORT_MIDI,
		PORT_BRDR
	} port_e;

	// ========================================
	// MIDI transmit timer
	// ========================================
	typedef enum logic {
		MIDI_IDLE,
		MIDI_SEND
	} midi_state_e;

	// clk_sys cycles per 1 us tick
	localparam int TICK_DIV        = 96;
	// One byte on the wire, start to stop bit
	localparam int MIDI_BYTE_TICKS = 320;
	localparam int MIDI_INT_AT     = 15;

	// Memory and audio widths
	localparam int PAGE_W  = 9;
	localparam int AUDIO_W = 16;

endpackage

// File: design/sam_port_ctrl.sv
/*
 * SAM ASIC port decoder
 * Edge-detects I/O writes, decodes the port and muxes port read data
 */

`timescale 1ns/1ps

module sam_port_ctrl (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic [7:0]     addr,
	input  logic [7:0]     din,
	input  logic           iorq,
	input  logic           rd,
	input  logic           wr,
	input  logic           m1,
	input  logic [7:0]     lmpr,
	input  logic [7:0]     hmpr,
	input  logic           int_midi,
	output logic           io_wr_stb,
	output sam_pkg::port_e port_id,
	output logic [7:0]     wr_data,
	output logic [7:0]     io_dout
);

	sam_pkg::port_e port_dec;
	logic           wr_lvl;
	logic           wr_lvl_q;
	logic           rd_lvl;
	logic [7:0]     rd_mux;

	assign wr_lvl = iorq & wr & m1 & ~rd;
	assign rd_lvl = iorq & rd & m1;

	// ========================================
	// Address decode
	// ========================================
	always_comb begin
		case (addr)
			sam_pkg::ADDR_EXT_C: port_dec = sam_pkg::PORT_EXT_C;
			sam_pkg::ADDR_EXT_D: port_dec = sam_pkg::PORT_EXT_D;
			sam_pkg::ADDR_LPTD:  port_dec = sam_pkg::PORT_LPTD;
			sam_pkg::ADDR_LPTS:  port_dec = sam_pkg::PORT_LPTS;
			sam_pkg::ADDR_STAT:  port_dec = sam_pkg::PORT_STAT;
			sam_pkg::ADDR_LMPR:  port_dec = sam_pkg::PORT_LMPR;
			sam_pkg::ADDR_HMPR:  port_dec = sam_pkg::PORT_HMPR;
			sam_pkg::ADDR_MIDI:  port_dec = sam_pkg::PORT_MIDI;
			sam_pkg::ADDR_BRDR:  port_dec = sam_pkg::PORT_BRDR;
			default:             port_dec = sam_pkg::PORT_NONE;
		endcase
	end

	// ========================================
	// Write strobe, one cycle per bus write
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_lvl_q  <= 1'b0;
			io_wr_stb <= 1'b0;
			port_id   <= sam_pkg::PORT_NONE;
		end else begin
			wr_lvl_q  <= wr_lvl;
			io_wr_stb <= wr_lvl & ~wr_lvl_q;
			port_id   <= port_dec;
		end
	end

	// Write data travels with the strobe
	always_ff @(posedge clk_sys) begin
		wr_data <= din;
	end

	// ========================================
	// Read-back mux
	// ========================================
	always_comb begin
		case (port_dec)
			// Frame and line interrupts are not modeled and read inactive
			sam_pkg::PORT_STAT: rd_mux = {3'b111, ~int_midi, 4'b1111};
			sam_pkg::PORT_LPTD: rd_mux = 8'h00;
			sam_pkg::PORT_LPTS: rd_mux = 8'h00;
			sam_pkg::PORT_LMPR: rd_mux = lmpr;
			sam_pkg::PORT_HMPR: rd_mux = hmpr;
			default:            rd_mux = 8'hFF;
		endcase
	end

	assign io_dout = rd_lvl ? rd_mux : 8'hFF;

endmodule

// File: design/sam_mem_map.sv
/*
 * SAM ASIC memory pager
 * LMPR, HMPR and external RAM bank registers, plus the CPU address to
 * RAM page, ROM select and RAM strobe mapping
 */

`timescale 1ns/1ps

module sam_mem_map (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       io_wr_stb,
	input  sam_pkg::port_e             port_id,
	input  logic [7:0]                 wr_data,
	input  logic [15:14]               addr,
	input  logic                       mreq,
	input  logic                       rd,
	input  logic                       wr,
	input  logic                       ext_ram_off,
	output logic [7:0]                 lmpr,
	output logic [7:0]                 hmpr,
	output logic [sam_pkg::PAGE_W-1:0] ram_page,
	output logic [1:0]                 rom_sel,
	output logic                       ram_rd,
	output logic                       ram_we
);

	logic [7:0] ext_c;
	logic [7:0] ext_d;
	logic       ext_dis;
	logic       ext_ram;
	logic       ram_wp;
	logic       ram_ena;
	logic [4:0] page_base;

	// ========================================
	// Paging registers
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lmpr    <= 8'h00;
			hmpr    <= 8'h00;
			ext_dis <= ext_ram_off;
		end else if (io_wr_stb) begin
			if (port_id == sam_pkg::PORT_LMPR)
				lmpr <= wr_data;
			if (port_id == sam_pkg::PORT_HMPR)
				hmpr <= wr_data;
		end
	end

	// External RAM banks keep their contents through reset
	always_ff @(posedge clk_sys) begin
		if (io_wr_stb && port_id == sam_pkg::PORT_EXT_C)
			ext_c <= wr_data;
		if (io_wr_stb && port_id == sam_pkg::PORT_EXT_D)
			ext_d <= wr_data;
	end

	// ========================================
	// Address mapping
	// ========================================
	assign rom_sel[0] = ~lmpr[5] & (addr == 2'd0);
	assign rom_sel[1] =  lmpr[6] & (addr == 2'd3);
	assign ram_wp     =  lmpr[7] & (addr == 2'd0);
	assign ext_ram    =  hmpr[7] & addr[15];
	assign ram_ena    = ~(ext_ram & ext_dis);

	// Sections A/B come from LMPR, C/D from HMPR
	assign page_base = addr[15] ? hmpr[4:0] : lmpr[4:0];

	always_comb begin
		if (ext_ram)
			ram_page = {1'b1, (addr[14] ? ext_d : ext_c)};
		else
			ram_page = sam_pkg::PAGE_W'(page_base) + sam_pkg::PAGE_W'(addr[14]);
	end

	assign ram_rd = mreq & rd & ~|rom_sel;
	assign ram_we = mreq & wr & ~|rom_sel & ~ram_wp & ram_ena;

endmodule

// File: design/sam_midi_tx.sv
/*
 * SAM ASIC MIDI output timer
 * Times one transmitted byte on a 1 us tick and raises the MIDI interrupt
 */

`timescale 1ns/1ps

module sam_midi_tx (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           io_wr_stb,
	input  sam_pkg::port_e port_id,
	output logic           midi_tx,
	output logic           int_midi
);

	logic [$clog2(sam_pkg::TICK_DIV)-1:0]        div_cnt;
	logic                                        tick;
	sam_pkg::midi_state_e                        state;
	logic [$clog2(sam_pkg::MIDI_BYTE_TICKS)-1:0] tx_cnt;
	logic                                        pending;

	// ========================================
	// 1 us tick from clk_sys
	// ========================================
	assign tick = (div_cnt == ($clog2(sam_pkg::TICK_DIV))'(sam_pkg::TICK_DIV - 1));

	always_ff @(posedge clk_sys) begin
		if (reset || tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// ========================================
	// Byte timer
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= sam_pkg::MIDI_IDLE;
			tx_cnt   <= '0;
			pending  <= 1'b0;
			midi_tx  <= 1'b0;
			int_midi <= 1'b0;
		end else begin
			if (tick) begin
				case (state)
					sam_pkg::MIDI_IDLE: begin
						if (pending) begin
							state   <= sam_pkg::MIDI_SEND;
							midi_tx <= 1'b1;
							tx_cnt  <= ($bits(tx_cnt))'(sam_pkg::MIDI_BYTE_TICKS - 1);
							pending <= 1'b0;
						end
					end
					sam_pkg::MIDI_SEND: begin
						if (tx_cnt == '0) begin
							state    <= sam_pkg::MIDI_IDLE;
							midi_tx  <= 1'b0;
							int_midi <= 1'b0;
						end else begin
							tx_cnt <= tx_cnt - 1'b1;
							// Interrupt near the end of the byte
							if (tx_cnt == ($bits(tx_cnt))'(sam_pkg::MIDI_INT_AT))
								int_midi <= 1'b1;
						end
					end
					default: state <= sam_pkg::MIDI_IDLE;
				endcase
			end
			// A new write wins over the start that clears the slot
			if (io_wr_stb && port_id == sam_pkg::PORT_MIDI)
				pending <= 1'b1;
		end
	end

endmodule

// File: design/sam_voice_dac.sv
/*
 * SAM ASIC voice DAC and beeper mix
 * Parallel port data latch, strobed left/right voice latches and the
 * border beeper, mixed into unsigned stereo
 */

`timescale 1ns/1ps

module sam_voice_dac (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        io_wr_stb,
	input  sam_pkg::port_e              port_id,
	input  logic [7:0]                  wr_data,
	output logic [sam_pkg::AUDIO_W-1:0] audio_l,
	output logic [sam_pkg::AUDIO_W-1:0] audio_r
);

	logic                          beep;
	logic [7:0]                    lpt_data;
	logic                          old_stb;
	logic [7:0]                    vox_l;
	logic [7:0]                    vox_r;
	logic [sam_pkg::AUDIO_W+2:0]   mix_l;
	logic [sam_pkg::AUDIO_W+2:0]   mix_r;
	logic [sam_pkg::AUDIO_W+2:0]   beep_lvl;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			beep     <= 1'b0;
			lpt_data <= 8'h00;
			old_stb  <= 1'b0;
			vox_l    <= 8'h00;
			vox_r    <= 8'h00;
		end else if (io_wr_stb) begin
			// Only the beeper bit of the border port reaches the audio
			if (port_id == sam_pkg::PORT_BRDR)
				beep <= wr_data[4];
			if (port_id == sam_pkg::PORT_LPTD)
				lpt_data <= wr_data;
			if (port_id == sam_pkg::PORT_LPTS) begin
				// Strobe rise loads left, fall loads right
				if (~old_stb & wr_data[0])
					vox_l <= lpt_data;
				if (old_stb & ~wr_data[0])
					vox_r <= lpt_data;
				old_stb <= wr_data[0];
			end
		end
	end

	// ========================================
	// Stereo mix
	// ========================================
	assign beep_lvl = ($bits(beep_lvl))'(beep) << 15;
	assign mix_l    = beep_lvl + ($bits(mix_l))'({vox_l, vox_l, 2'b00});
	assign mix_r    = beep_lvl + ($bits(mix_r))'({vox_r, vox_r, 2'b00});

	assign audio_l = mix_l[sam_pkg::AUDIO_W+2:3];
	assign audio_r = mix_r[sam_pkg::AUDIO_W+2:3];

endmodule

// File: design/sam_asic_top.sv
/*
 * SAM ASIC glue top level
 * Port decoder feeding the memory pager, MIDI timer and voice DAC
 */

`timescale 1ns/1ps

module sam_asic_top (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic [15:0]                 addr,
	input  logic [7:0]                  din,
	input  logic                        mreq,
	input  logic                        iorq,
	input  logic                        rd,
	input  logic                        wr,
	input  logic                        m1,
	input  logic                        ext_ram_off,
	output logic [7:0]                  io_dout,
	output logic [sam_pkg::PAGE_W-1:0]  ram_page,
	output logic [1:0]                  rom_sel,
	output logic                        ram_rd,
	output logic                        ram_we,
	output logic                        midi_tx,
	output logic                        int_midi,
	output logic [sam_pkg::AUDIO_W-1:0] audio_l,
	output logic [sam_pkg::AUDIO_W-1:0] audio_r
);

	logic           io_wr_stb;
	sam_pkg::port_e port_id;
	logic [7:0]     wr_data;
	logic [7:0]     lmpr;
	logic [7:0]     hmpr;

	sam_port_ctrl u_port_ctrl (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.addr      (addr[7:0]),
		.din       (din),
		.iorq      (iorq),
		.rd        (rd),
		.wr        (wr),
		.m1        (m1),
		.lmpr      (lmpr),
		.hmpr      (hmpr),
		.int_midi  (int_midi),
		.io_wr_stb (io_wr_stb),
		.port_id   (port_id),
		.wr_data   (wr_data),
		.io_dout   (io_dout)
	);

	sam_mem_map u_mem_map (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.io_wr_stb   (io_wr_stb),
		.port_id     (port_id),
		.wr_data     (wr_data),
		.addr        (addr[15:14]),
		.mreq        (mreq),
		.rd          (rd),
		.wr          (wr),
		.ext_ram_off (ext_ram_off),
		.lmpr        (lmpr),
		.hmpr        (hmpr),
		.ram_page    (ram_page),
		.rom_sel     (rom_sel),
		.ram_rd      (ram_rd),
		.ram_we      (ram_we)
	);

	sam_midi_tx u_midi_tx (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_wr_stb (io_wr_stb),
		.port_id   (port_id),
		.midi_tx   (midi_tx),
		.int_midi  (int_midi)
	);

	sam_voice_dac u_voice_dac (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_wr_stb (io_wr_stb),
		.port_id   (port_id),
		.wr_data   (wr_data),
		.audio_l   (audio_l),
		.audio_r   (audio_r)
	);

endmodule

// File: testbench/sam_asic_asserts.sv
/*
 * SAM ASIC glue assertions
 * Write strobe width, ROM write guard and MIDI interrupt framing
 */

`timescale 1ns/1ps

module sam_asic_asserts (
	input logic       clk_sys,
	input logic       reset,
	input logic       io_wr_stb,
	input logic       ram_we,
	input logic [1:0] rom_sel,
	input logic       midi_tx,
	input logic       int_midi
);

	int fail_cnt = 0;

	// One strobe per bus write
	stb_single: assert property (@(posedge clk_sys) disable iff (reset)
		io_wr_stb |=> !io_wr_stb)
		else begin
			$error("io_wr_stb stayed high for two cycles");
			fail_cnt++;
		end

	// ROM is never written
	we_no_rom: assert property (@(posedge clk_sys) disable iff (reset)
		!(ram_we && rom_sel != 2'b00))
		else begin
			$error("ram_we asserted while a ROM is selected");
			fail_cnt++;
		end

	int_in_byte: assert property (@(posedge clk_sys) disable iff (reset)
		int_midi |-> midi_tx)
		else begin
			$error("int_midi high while midi_tx is low");
			fail_cnt++;
		end

endmodule

bind sam_asic_top sam_asic_asserts u_asserts (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.io_wr_stb (io_wr_stb),
	.ram_we    (ram_we),
	.rom_sel   (rom_sel),
	.midi_tx   (midi_tx),
	.int_midi  (int_midi)
);

// File: testbench/tb_sam_asic.sv
/*
 * Testbench for the SAM ASIC glue subsystem
 * Directed bus-level tests of paging, port read-back, voice DAC and MIDI timer
 */

`timescale 1ns/1ps

module tb_sam_asic;

	localparam int CLK_NS   = 100;
	localparam int TICK     = sam_pkg::TICK_DIV;
	localparam int BYTE_CYC = sam_pkg::MIDI_BYTE_TICKS * sam_pkg::TICK_DIV;
	localparam longint WATCHDOG_NS = longint'(10 * BYTE_CYC + 2000) * CLK_NS;

	logic        clk_sys;
	logic        reset;
	logic [15:0] addr;
	logic [7:0]  din;
	logic        mreq;
	logic        iorq;
	logic        rd;
	logic        wr;
	logic        m1;
	logic        ext_ram_off;
	logic [7:0]  io_dout;
	logic [8:0]  ram_page;
	logic [1:0]  rom_sel;
	logic        ram_rd;
	logic        ram_we;
	logic        midi_tx;
	logic        int_midi;
	logic [15:0] audio_l;
	logic [15:0] audio_r;

	// Reference copies of the DUT registers
	logic [7:0]  m_lmpr;
	logic [7:0]  m_hmpr;
	logic [7:0]  m_ext_c;
	logic [7:0]  m_ext_d;
	logic [7:0]  m_lpt;
	logic [7:0]  m_vox_l;
	logic [7:0]  m_vox_r;
	logic        m_old_stb;
	logic        m_beep;
	logic        m_ext_off;

	logic [15:0] lfsr;
	int          err_cnt;
	int          err_mark;
	int          chk_cnt;
	int          test_cnt;
	time         t_rise;
	time         t_fall;

	sam_asic_top u_dut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.addr        (addr),
		.din         (din),
		.mreq        (mreq),
		.iorq        (iorq),
		.rd          (rd),
		.wr          (wr),
		.m1          (m1),
		.ext_ram_off (ext_ram_off),
		.io_dout     (io_dout),
		.ram_page    (ram_page),
		.rom_sel     (rom_sel),
		.ram_rd      (ram_rd),
		.ram_we      (ram_we),
		.midi_tx     (midi_tx),
		.int_midi    (int_midi),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	initial clk_sys = 1'b0;
	always #(CLK_NS / 2) clk_sys = ~clk_sys;

	always @(posedge midi_tx) t_rise = $time;
	always @(negedge midi_tx) t_fall = $time;

	// Ten MIDI bytes plus slack for the bus tests
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t, a test did not finish", $time);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ========================================
	// Helpers
	// ========================================
	// Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] b;
		b = 8'h00;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			b    = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	// Border bit at 2^15 plus the doubled voice byte at 2^2, top 16 of 19 bits
	function automatic logic [15:0] mix_level(input logic b, input logic [7:0] v);
		logic [18:0] s;
		s = 19'(b) << 15;
		s = s + (19'({v, v}) << 2);
		return s[18:3];
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		chk_cnt++;
		assert (got === exp) else begin
			$display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic require(input logic cond, input string what);
		chk_cnt++;
		assert (cond === 1'b1) else begin
			$display("Check failed at %0t: %s", $time, what);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name);
		test_cnt++;
		if (err_cnt == err_mark)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, err_cnt - err_mark);
		err_mark = err_cnt;
	endtask

	task automatic apply_reset(input logic off);
		@(negedge clk_sys);
		reset       = 1'b1;
		ext_ram_off = off;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset     = 1'b0;
		m_lmpr    = 8'h00;
		m_hmpr    = 8'h00;
		m_lpt     = 8'h00;
		m_vox_l   = 8'h00;
		m_vox_r   = 8'h00;
		m_old_stb = 1'b0;
		m_beep    = 1'b0;
		m_ext_off = off;
	endtask

	task automatic port_write(input logic [7:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		addr = {8'h00, a};
		din  = d;
		iorq = 1'b1;
		wr   = 1'b1;
		m1   = 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		iorq = 1'b0;
		wr   = 1'b0;
		m1   = 1'b0;
		case (a)
			sam_pkg::ADDR_LMPR:  m_lmpr  = d;
			sam_pkg::ADDR_HMPR:  m_hmpr  = d;
			sam_pkg::ADDR_EXT_C: m_ext_c = d;
			sam_pkg::ADDR_EXT_D: m_ext_d = d;
			sam_pkg::ADDR_LPTD:  m_lpt   = d;
			sam_pkg::ADDR_BRDR:  m_beep  = d[4];
			sam_pkg::ADDR_LPTS: begin
				if (!m_old_stb && d[0])
					m_vox_l = m_lpt;
				if (m_old_stb && !d[0])
					m_vox_r = m_lpt;
				m_old_stb = d[0];
			end
			default: ;
		endcase
	endtask

	task automatic port_read(input logic [7:0] a, output logic [7:0] d);
		@(negedge clk_sys);
		addr = {8'h00, a};
		iorq = 1'b1;
		rd   = 1'b1;
		m1   = 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		d    = io_dout;
		iorq = 1'b0;
		rd   = 1'b0;
		m1   = 1'b0;
	endtask

	// Memory cycle, checked against the paging rules
	task automatic mem_access(input logic [15:0] a, input logic is_wr);
		logic [1:0] q;
		logic [1:0] rom;
		logic       ext;
		logic       wp;
		logic       ena;
		logic [8:0] page;
		q      = a[15:14];
		rom[0] = !m_lmpr[5] && q == 2'd0;
		rom[1] = m_lmpr[6] && q == 2'd3;
		ext    = m_hmpr[7] && q[1];
		wp     = m_lmpr[7] && q == 2'd0;
		ena    = !(ext && m_ext_off);
		if (ext)
			page = {1'b1, (q[0] ? m_ext_d : m_ext_c)};
		else
			page = 9'(q[1] ? m_hmpr[4:0] : m_lmpr[4:0]) + 9'(q[0]);
		@(negedge clk_sys);
		addr = a;
		mreq = 1'b1;
		rd   = !is_wr;
		wr   = is_wr;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		compare("ram_page", 32'(ram_page), 32'(page));
		compare("rom_sel", 32'(rom_sel), 32'(rom));
		compare("ram_rd", 32'(ram_rd), 32'(!is_wr && rom == 2'b00));
		compare("ram_we", 32'(ram_we), 32'(is_wr && rom == 2'b00 && !wp && ena));
		mreq = 1'b0;
		rd   = 1'b0;
		wr   = 1'b0;
	endtask

	task automatic compare_audio();
		compare("audio_l", 32'(audio_l), 32'(mix_level(m_beep, m_vox_l)));
		compare("audio_r", 32'(audio_r), 32'(mix_level(m_beep, m_vox_r)));
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic reset_defaults();
		logic [7:0] d;
		port_read(sam_pkg::ADDR_LMPR, d);
		compare("io_dout", 32'(d), 32'h00);
		port_read(sam_pkg::ADDR_HMPR, d);
		compare("io_dout", 32'(d), 32'h00);
		port_read(sam_pkg::ADDR_STAT, d);
		compare("io_dout", 32'(d), 32'hFF);
		// Printer ports read as zero, unmapped reads float high
		port_read(sam_pkg::ADDR_LPTS, d);
		compare("io_dout", 32'(d), 32'h00);
		port_read(sam_pkg::ADDR_BRDR, d);
		compare("io_dout", 32'(d), 32'hFF);
		compare("midi_tx", 32'(midi_tx), 32'h0);
		compare("int_midi", 32'(int_midi), 32'h0);
		compare("audio_l", 32'(audio_l), 32'h0);
		compare("audio_r", 32'(audio_r), 32'h0);
		// LMPR is 0, so ROM 0 sits in the bottom quarter
		mem_access(16'h0000, 1'b0);
	endtask

	task automatic paging_map();
		logic [7:0]  l;
		logic [7:0]  h;
		logic [7:0]  d;
		logic [15:0] a;
		for (int n = 0; n < 6; n++) begin
			l = rand_bits(8);
			h = rand_bits(7);
			port_write(sam_pkg::ADDR_LMPR, l);
			port_write(sam_pkg::ADDR_HMPR, h);
			port_read(sam_pkg::ADDR_LMPR, d);
			compare("io_dout", 32'(d), 32'(l));
			port_read(sam_pkg::ADDR_HMPR, d);
			compare("io_dout", 32'(d), 32'(h));
			for (int q = 0; q < 4; q++) begin
				d = rand_bits(6);
				a = {q[1:0], d[5:0], rand_bits(8)};
				mem_access(a, 1'b0);
				mem_access(a, 1'b1);
			end
		end
		// Write protect on, ROM 0 paged out
		port_write(sam_pkg::ADDR_LMPR, 8'hA3);
		mem_access(16'h1234, 1'b1);
		mem_access(16'h1234, 1'b0);
	endtask

	task automatic ext_ram_banks();
		port_write(sam_pkg::ADDR_LMPR, rand_bits(5));
		port_write(sam_pkg::ADDR_EXT_C, rand_bits(8));
		port_write(sam_pkg::ADDR_EXT_D, rand_bits(8));
		port_write(sam_pkg::ADDR_HMPR, rand_bits(7) | 8'h80);
		mem_access(16'h8155, 1'b0);
		mem_access(16'h8155, 1'b1);
		mem_access(16'hC2AA, 1'b0);
		mem_access(16'hC2AA, 1'b1);
		// Bank registers survive reset, the disable flag is sampled here
		apply_reset(1'b1);
		port_write(sam_pkg::ADDR_HMPR, 8'h80);
		mem_access(16'h8000, 1'b1);
		mem_access(16'h8000, 1'b0);
		mem_access(16'hC000, 1'b1);
		mem_access(16'hC000, 1'b0);
		apply_reset(1'b0);
	endtask

	task automatic voice_mix();
		port_write(sam_pkg::ADDR_BRDR, 8'h00);
		port_write(sam_pkg::ADDR_LPTS, 8'h00);
		port_write(sam_pkg::ADDR_LPTD, rand_bits(8));
		port_write(sam_pkg::ADDR_LPTS, 8'h01);
		compare_audio();
		// Strobe stays high, so no latch should load
		port_write(sam_pkg::ADDR_LPTD, rand_bits(8));
		port_write(sam_pkg::ADDR_LPTS, 8'h01);
		compare_audio();
		port_write(sam_pkg::ADDR_LPTS, 8'h00);
		compare_audio();
		port_write(sam_pkg::ADDR_BRDR, 8'h10);
		compare_audio();
		port_write(sam_pkg::ADDR_BRDR, 8'hEF);
		compare_audio();
	endtask

	task automatic midi_timer();
		time        t0;
		time        rise1;
		time        fall1;
		logic [7:0] d;
		int         n;
		// Write level is driven on the next falling edge
		t0 = $time + CLK_NS;
		port_write(sam_pkg::ADDR_MIDI, rand_bits(8));
		n = 0;
		while (!midi_tx && n < TICK + 8) begin
			@(negedge clk_sys);
			n++;
		end
		require(midi_tx, "midi_tx did not rise after a MIDI write");
		require(t_rise - t0 <= (TICK + 3) * CLK_NS, "midi_tx rose too late after the write");
		rise1 = t_rise;
		d = 8'hFF;
		n = 0;
		while (d[4] && midi_tx && n < BYTE_CYC / 4 + 50) begin
			port_read(sam_pkg::ADDR_STAT, d);
			n++;
		end
		compare("io_dout", 32'(d), 32'hEF);
		require(midi_tx, "MIDI interrupt was not seen while midi_tx was high");
		// Second byte queued while the first is still on the wire
		port_write(sam_pkg::ADDR_MIDI, rand_bits(8));
		n = 0;
		while (midi_tx && n < BYTE_CYC) begin
			@(negedge clk_sys);
			n++;
		end
		require(!midi_tx, "first MIDI byte never ended");
		compare("int_midi", 32'(int_midi), 32'h0);
		fall1 = t_fall;
		require(fall1 - rise1 >= (BYTE_CYC - TICK) * CLK_NS &&
			fall1 - rise1 <= (BYTE_CYC + TICK) * CLK_NS,
			"first MIDI byte length is outside the expected window");
		n = 0;
		while (!midi_tx && n < TICK + 8) begin
			@(negedge clk_sys);
			n++;
		end
		require(midi_tx, "pending MIDI write did not start a second byte");
		require(t_rise - fall1 <= (TICK + 1) * CLK_NS, "second byte did not follow the first");
		n = 0;
		while (midi_tx && n < BYTE_CYC + 8) begin
			@(negedge clk_sys);
			n++;
		end
		require(!midi_tx, "second MIDI byte never ended");
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		reset       = 1'b1;
		addr        = 16'h0000;
		din         = 8'h00;
		mreq        = 1'b0;
		iorq        = 1'b0;
		rd          = 1'b0;
		wr          = 1'b0;
		m1          = 1'b0;
		ext_ram_off = 1'b0;
		m_ext_c     = 8'h00;
		m_ext_d     = 8'h00;
		lfsr        = 16'd28;
		err_cnt     = 0;
		err_mark    = 0;
		chk_cnt     = 0;
		test_cnt    = 0;
		t_rise      = 0;
		t_fall      = 0;
		apply_reset(1'b0);

		reset_defaults();
		report_test("reset defaults");
		paging_map();
		report_test("paging");
		ext_ram_banks();
		report_test("external RAM");
		voice_mix();
		report_test("voice DAC and beeper");
		midi_timer();
		report_test("MIDI timer");

		err_cnt = err_cnt + u_dut.u_asserts.fail_cnt;
		$display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
design/sam_pkg.sv
design/sam_port_ctrl.sv
design/sam_mem_map.sv
design/sam_midi_tx.sv
design/sam_voice_dac.sv
design/sam_asic_top.sv
testbench/sam_asic_asserts.sv
testbench/tb_sam_asic.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the SAM ASIC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_sam_asic -f flist.f -o sim_sam_asic

# The grep below decides the result, so a non-zero exit here is tolerated
out=$(./obj_dir/sim_sam_asic || true)
echo "$out"

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1
